//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_tcdm_adapter
FLIST     = tb.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJDIR)

//--- design/amo_alu.sv
// ------------------------------
// combinational AMO result
// min/max share the add path as a 33-bit subtract
// non-rmw opcodes pass the old word through
// ------------------------------
`timescale 1ns/1ps

module amo_alu import tcdm_pkg::*, amo_pkg::*; (
  input  amo_op_t op_i,
  input  data_t   operand_i,
  input  data_t   mem_i,
  output data_t   result_o
);

  logic [data_width:0] add_a;
  logic [data_width:0] add_b;
  logic [data_width:0] sum;
  logic                sub;
  logic                sext;
  logic                lt;

  // signed compares extend with the sign bit, unsigned with zero
  assign sext = op_i inside {amo_max, amo_min};
  assign sub  = op_i inside {amo_max, amo_maxu, amo_min, amo_minu};

  assign add_a = {sext & mem_i[data_width-1], mem_i};
  assign add_b = {sext & operand_i[data_width-1], operand_i};

  // mem - operand when comparing, plain sum for add
  assign sum = add_a + (sub ? ~add_b : add_b) + {{data_width{1'b0}}, sub};

  // sign of the extended difference, so mem < operand
  assign lt = sum[data_width];

  always_comb begin
    case (op_i)
      amo_swap: result_o = operand_i;
      amo_add:  result_o = sum[data_width-1:0];
      amo_and:  result_o = mem_i & operand_i;
      amo_or:   result_o = mem_i | operand_i;
      amo_xor:  result_o = mem_i ^ operand_i;
      // keep the larger one
      amo_max,
      amo_maxu: result_o = lt ? operand_i : mem_i;
      // keep the smaller one
      amo_min,
      amo_minu: result_o = lt ? mem_i : operand_i;
      default:  result_o = mem_i;
    endcase
  end

endmodule

//--- design/amo_pkg.sv
// ------------------------------
// atomic opcode encoding on the core port
// codes 12 to 15 are unused and behave as none
// ------------------------------
package amo_pkg;

  localparam int unsigned amo_width = 4;

  typedef enum logic [amo_width-1:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_maxu = 4'h7,
    amo_min  = 4'h8,
    amo_minu = 4'h9,
    amo_lr   = 4'ha,
    amo_sc   = 4'hb
  } amo_op_t;

  // read-modify-write ops, served as read then write-back
  function automatic logic is_rmw(amo_op_t op);
    return op inside {[amo_swap:amo_minu]};
  endfunction

  // plain load or store, no atomic semantics
  function automatic logic is_plain(amo_op_t op);
    return !(op inside {[amo_swap:amo_sc]});
  endfunction

endpackage

//--- design/bank_sequencer.sv
// ------------------------------
// request acceptance and SRAM port control
// SRAM grants in the same cycle, read data one cycle later
// AMO blocks the port for one write-back cycle
// ------------------------------
`timescale 1ns/1ps

module bank_sequencer import tcdm_pkg::*, amo_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  tcdm_req_if.seq        req,
  input  logic           sc_success_i,
  input  logic           resp_busy_i,
  input  data_t          mem_rdata_i,
  output logic           out_req_o,
  output addr_t          out_add_o,
  output logic           out_write_o,
  output data_t          out_wdata_o,
  output be_t            out_be_o
);

  logic    accept;
  logic    rmw_accept;

  // AMO machine, low is idle, high is write-back
  logic    amo_wb_q;

  // captured AMO request
  amo_op_t amo_op_q;
  addr_t   amo_addr_q;
  data_t   amo_operand_q;
  data_t   amo_result;

  // ------------------------------
  // handshake
  // ------------------------------
  // stall during write-back and while a response waits for the core
  assign req.ready  = !amo_wb_q && !resp_busy_i;
  assign accept     = req.valid && req.ready;
  assign rmw_accept = accept && is_rmw(req.amo);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      amo_wb_q <= 1'b0;
    end else begin
      // write-back always lasts exactly one cycle
      amo_wb_q <= rmw_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rmw_accept) begin
      amo_op_q      <= req.amo;
      amo_addr_q    <= req.addr;
      amo_operand_q <= req.wdata;
    end
  end

  // old word arrives from the SRAM in the write-back cycle
  amo_alu i_amo_alu (
    .op_i      (amo_op_q),
    .operand_i (amo_operand_q),
    .mem_i     (mem_rdata_i),
    .result_o  (amo_result)
  );

  // ------------------------------
  // SRAM port
  // ------------------------------
  always_comb begin
    if (amo_wb_q) begin
      // commit the AMO result over the whole word
      out_req_o   = 1'b1;
      out_write_o = 1'b1;
      out_add_o   = amo_addr_q;
      out_wdata_o = amo_result;
      out_be_o    = be_full;
    end else begin
      out_req_o = accept;
      // SC writes only on success, AMO and LR read first
      if (req.amo == amo_sc) begin
        out_write_o = accept && sc_success_i;
      end else begin
        out_write_o = accept && req.write && is_plain(req.amo);
      end
      out_add_o   = req.addr;
      out_wdata_o = req.wdata;
      out_be_o    = req.be;
    end
  end

  // AMO read is always followed by its write-back, with the core held off
  amo_wb_follows : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rmw_accept |=> (!accept && out_req_o && out_write_o))
    else $error("AMO write-back missing or request accepted during write-back");

endmodule

//--- design/lrsc_monitor.sv
// ------------------------------
// single LR/SC reservation, one word wide
// owner is ini_addr, tile_id and core_id of the LR
// ------------------------------
`timescale 1ns/1ps

module lrsc_monitor import tcdm_pkg::*, amo_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  tcdm_req_if.mon req,
  output logic    sc_success_o
);

  logic  accept;
  logic  owner_match;
  logic  addr_match;
  logic  set_res;
  logic  kill_res;
  logic  sc_owner;

  // reservation state, meta_id of the owner is ignored
  logic  res_valid_q;
  addr_t res_addr_q;
  meta_t res_owner_q;

  assign accept = req.valid && req.ready;

  assign owner_match = (res_owner_q.ini_addr == req.meta.ini_addr) &&
                       (res_owner_q.tile_id  == req.meta.tile_id)  &&
                       (res_owner_q.core_id  == req.meta.core_id);
  assign addr_match  = (res_addr_q == req.addr);

  // LR takes a free reservation or renews its own
  assign set_res  = accept && (req.amo == amo_lr) && (!res_valid_q || owner_match);
  // any store or rmw to the reserved word breaks it
  assign kill_res = accept && addr_match &&
                    ((req.write && is_plain(req.amo)) || is_rmw(req.amo));
  // any SC of the owner consumes the reservation
  assign sc_owner = accept && (req.amo == amo_sc) && res_valid_q && owner_match;

  // success decided in the acceptance cycle, write goes out the same cycle
  assign sc_success_o = sc_owner && addr_match;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else if (kill_res || sc_owner) begin
      res_valid_q <= 1'b0;
    end else if (set_res) begin
      res_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (set_res) begin
      res_addr_q  <= req.addr;
      res_owner_q <= req.meta;
    end
  end

endmodule

//--- design/resp_buffer.sv
// ------------------------------
// response path, metadata FIFO of two and one data entry
// data register falls through, so N+1 response is possible
// stores produce no response
// ------------------------------
`timescale 1ns/1ps

module resp_buffer import tcdm_pkg::*, amo_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  tcdm_req_if.mon req,
  input  logic    sc_success_i,
  input  data_t   mem_rdata_i,
  output logic    resp_busy_o,
  output logic    in_valid_o,
  input  logic    in_ready_i,
  output data_t   in_rdata_o,
  output meta_t   in_meta_o
);

  logic       push_meta;
  logic       pop;
  logic       load_data;

  // ------------------------------
  // metadata spill
  // ------------------------------
  meta_t      meta_mem_q [2];
  logic       meta_wptr_q;
  logic       meta_rptr_q;
  logic [1:0] meta_cnt_q;

  // ------------------------------
  // data register
  // ------------------------------
  logic       push_data_q;
  logic       sc_q;
  logic       sc_ok_q;
  logic       data_valid_q;
  data_t      data_q;
  data_t      data_in;

  // every accepted request except a plain store answers
  assign push_meta = req.valid && req.ready && !(req.write && is_plain(req.amo));
  assign pop       = in_valid_o && in_ready_i;

  // SC answers 0 on success, 1 on failure
  assign data_in    = sc_q ? data_t'(!sc_ok_q) : mem_rdata_i;
  assign in_rdata_o = data_valid_q ? data_q : data_in;
  assign in_meta_o  = meta_mem_q[meta_rptr_q];

  // data always trails its metadata by at least one cycle
  assign in_valid_o  = (meta_cnt_q != 2'd0) && (data_valid_q || push_data_q);
  assign resp_busy_o = in_valid_o && !in_ready_i;

  // store incoming data unless it leaves right away, or refill after a pop
  assign load_data = push_data_q && (data_valid_q == pop);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_wptr_q  <= 1'b0;
      meta_rptr_q  <= 1'b0;
      meta_cnt_q   <= 2'd0;
      push_data_q  <= 1'b0;
      sc_q         <= 1'b0;
      data_valid_q <= 1'b0;
    end else begin
      if (push_meta) begin
        meta_wptr_q <= !meta_wptr_q;
      end
      if (pop) begin
        meta_rptr_q <= !meta_rptr_q;
      end
      meta_cnt_q  <= meta_cnt_q + {1'b0, push_meta} - {1'b0, pop};
      // SRAM word or SC flag is due one cycle after acceptance
      push_data_q <= push_meta;
      sc_q        <= push_meta && (req.amo == amo_sc);
      if (data_valid_q) begin
        data_valid_q <= !pop || push_data_q;
      end else begin
        data_valid_q <= push_data_q && !pop;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_meta) begin
      meta_mem_q[meta_wptr_q] <= req.meta;
    end
    sc_ok_q <= sc_success_i;
    if (load_data) begin
      data_q <= data_in;
    end
  end

  // back-pressure upstream must keep room for the data of every accepted read
  rdata_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_meta |=> (!data_valid_q || pop))
    else $error("read data pushed into a full data register");

endmodule

//--- design/tcdm_adapter.sv
// ------------------------------
// TCDM bank front end, valid/ready to SRAM req/grant
// needs exclusive access to a single-cycle SRAM
// one LR/SC reservation for the whole bank
// ------------------------------
`timescale 1ns/1ps

module tcdm_adapter import tcdm_pkg::*, amo_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // core request
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  addr_t                in_address_i,
  input  logic [amo_width-1:0] in_amo_i,
  input  logic                 in_write_i,
  input  data_t                in_wdata_i,
  input  meta_t                in_meta_i,
  input  be_t                  in_be_i,
  // core response
  output logic                 in_valid_o,
  input  logic                 in_ready_i,
  output data_t                in_rdata_o,
  output meta_t                in_meta_o,
  // SRAM port
  output logic                 out_req_o,
  output addr_t                out_add_o,
  output logic                 out_write_o,
  output data_t                out_wdata_o,
  output be_t                  out_be_o,
  input  data_t                out_rdata_i
);

  logic sc_success;
  logic resp_busy;

  tcdm_req_if req_if ();

  // core side of the request bundle
  assign req_if.valid = in_valid_i;
  assign req_if.addr  = in_address_i;
  assign req_if.amo   = amo_op_t'(in_amo_i);
  assign req_if.write = in_write_i;
  assign req_if.wdata = in_wdata_i;
  assign req_if.be    = in_be_i;
  assign req_if.meta  = in_meta_i;
  assign in_ready_o   = req_if.ready;

  bank_sequencer i_bank_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req          (req_if),
    .sc_success_i (sc_success),
    .resp_busy_i  (resp_busy),
    .mem_rdata_i  (out_rdata_i),
    .out_req_o    (out_req_o),
    .out_add_o    (out_add_o),
    .out_write_o  (out_write_o),
    .out_wdata_o  (out_wdata_o),
    .out_be_o     (out_be_o)
  );

  lrsc_monitor i_lrsc_monitor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req          (req_if),
    .sc_success_o (sc_success)
  );

  resp_buffer i_resp_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req          (req_if),
    .sc_success_i (sc_success),
    .mem_rdata_i  (out_rdata_i),
    .resp_busy_o  (resp_busy),
    .in_valid_o   (in_valid_o),
    .in_ready_i   (in_ready_i),
    .in_rdata_o   (in_rdata_o),
    .in_meta_o    (in_meta_o)
  );

endmodule

//--- design/tcdm_pkg.sv
// ------------------------------
// bank port widths and request metadata
// fixed 32-bit word; byte enables cover one word
// ------------------------------
package tcdm_pkg;

  // ------------------------------
  // bank port widths
  // ------------------------------
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned be_width   = data_width / 8;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [be_width-1:0]   be_t;

  // AMO write-back always stores the full word
  localparam be_t be_full = '1;

  // request metadata, returned unchanged with the response
  // ini_addr, tile_id and core_id together name the issuing core
  typedef struct packed {
    logic [2:0] ini_addr;
    logic [3:0] tile_id;
    logic [2:0] core_id;
    logic [5:0] meta_id;
  } meta_t;

endpackage

//--- design/tcdm_req_if.sv
// ------------------------------
// accepted core request toward the bank
// transfer when valid and ready are both high
// valid must not depend on ready
// ------------------------------
`timescale 1ns/1ps

interface tcdm_req_if import tcdm_pkg::*, amo_pkg::*; ();

  logic    valid;
  logic    ready;
  addr_t   addr;
  amo_op_t amo;
  logic    write;
  data_t   wdata;
  be_t     be;
  meta_t   meta;

  // core side, drives the request
  modport src (output valid, addr, amo, write, wdata, be, meta, input ready);

  // bank sequencer, owns ready
  modport seq (input valid, addr, amo, write, wdata, be, output ready);

  // observers of accepted requests
  modport mon (input valid, ready, addr, amo, write, wdata, be, meta);

endinterface

//--- tb.f
design/tcdm_pkg.sv
design/amo_pkg.sv
design/tcdm_req_if.sv
design/amo_alu.sv
design/bank_sequencer.sv
design/lrsc_monitor.sv
design/resp_buffer.sv
design/tcdm_adapter.sv
test/tb_tcdm_adapter.sv

//--- test/tb_tcdm_adapter.sv
// ------------------------------
// testbench for the TCDM bank front end
// 64-word SRAM model, one cycle read latency
// every request uses full byte enables
// ------------------------------
`timescale 1ns/1ps

module tb_tcdm_adapter import tcdm_pkg::*, amo_pkg::*; ();

  localparam int max_tab = 64;
  localparam logic [9:0] core_a = {3'd1, 4'd2, 3'd3};
  // same core_id as core_a, other tile
  localparam logic [9:0] core_b = {3'd5, 4'd0, 3'd3};

  logic        clk_i;
  logic        rst_ni;
  logic        in_valid_i;
  logic        in_ready_o;
  addr_t       in_address_i;
  logic [3:0]  in_amo_i;
  logic        in_write_i;
  data_t       in_wdata_i;
  meta_t       in_meta_i;
  be_t         in_be_i;
  logic        in_valid_o;
  logic        in_ready_i;
  data_t       in_rdata_o;
  meta_t       in_meta_o;
  logic        out_req_o;
  addr_t       out_add_o;
  logic        out_write_o;
  data_t       out_wdata_o;
  be_t         out_be_o;
  data_t       out_rdata_i;

  int          seed = 28328;
  int          errors;
  int          checks;
  int          tab_len;
  int          i;

  // stimulus table, exp holds the answer of SC rows only
  logic [3:0]  tab_op   [max_tab];
  logic        tab_we   [max_tab];
  logic [5:0]  tab_idx  [max_tab];
  data_t       tab_data [max_tab];
  logic [9:0]  tab_core [max_tab];
  data_t       tab_exp  [max_tab];

  data_t       sram   [64];
  data_t       shadow [64];
  data_t       exp_data_q [$];
  meta_t       exp_meta_q [$];

  tcdm_adapter dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------
  // reference helpers
  // ------------------------------
  function automatic data_t fill_word(input int idx);
    return data_t'(idx + 1) * 32'h9e37_79b9;
  endfunction

  // RISC-V AMO result from old word and operand
  function automatic data_t amo_ref(input logic [3:0] op, input data_t old, input data_t opnd);
    data_t r;
    case (op)
      amo_swap: r = opnd;
      amo_add:  r = old + opnd;
      amo_and:  r = old & opnd;
      amo_or:   r = old | opnd;
      amo_xor:  r = old ^ opnd;
      amo_max:  r = ($signed(old) > $signed(opnd)) ? old : opnd;
      amo_maxu: r = (old > opnd) ? old : opnd;
      amo_min:  r = ($signed(old) < $signed(opnd)) ? old : opnd;
      amo_minu: r = (old < opnd) ? old : opnd;
      default:  r = old;
    endcase
    return r;
  endfunction

  task automatic add_entry(input logic [3:0] op, input logic we, input logic [5:0] idx,
                           input data_t data, input logic [9:0] core, input data_t exp);
    tab_op[tab_len]   = op;
    tab_we[tab_len]   = we;
    tab_idx[tab_len]  = idx;
    tab_data[tab_len] = data;
    tab_core[tab_len] = core;
    tab_exp[tab_len]  = exp;
    tab_len++;
  endtask

  // AMO followed by a load of the same word from another core
  task automatic add_amo_readback(input logic [3:0] op, input logic [5:0] idx, input data_t opnd);
    add_entry(op, 1'b0, idx, opnd, core_a, '0);
    add_entry(amo_none, 1'b0, idx, '0, core_b, '0);
  endtask

  task automatic build_table();
    tab_len = 0;
    // store then load, then loads back to back
    add_entry(amo_none, 1'b1, 6'd3, 32'h1234_5678, core_a, '0);
    add_entry(amo_none, 1'b0, 6'd3, '0, core_a, '0);
    add_entry(amo_none, 1'b1, 6'd4, 32'hdead_beef, core_b, '0);
    add_entry(amo_none, 1'b0, 6'd4, '0, core_b, '0);
    add_entry(amo_none, 1'b0, 6'd3, '0, core_b, '0);
    add_amo_readback(amo_swap, 6'd10, 32'h0bad_f00d);
    add_amo_readback(amo_add,  6'd11, 32'h7fff_ffff);
    add_amo_readback(amo_and,  6'd12, 32'h0ff0_f0f0);
    add_amo_readback(amo_or,   6'd13, 32'h1234_0001);
    add_amo_readback(amo_xor,  6'd14, 32'hffff_0000);
    add_amo_readback(amo_max,  6'd15, 32'h7000_0000);
    add_amo_readback(amo_maxu, 6'd16, 32'h8000_0001);
    add_amo_readback(amo_min,  6'd17, 32'h0000_0100);
    add_amo_readback(amo_minu, 6'd18, 32'h9000_0000);
    // LR then SC of the same core succeeds
    add_entry(amo_lr,   1'b0, 6'd20, '0, core_a, '0);
    add_entry(amo_sc,   1'b0, 6'd20, 32'h5c5c_0001, core_a, 32'd0);
    add_entry(amo_none, 1'b0, 6'd20, '0, core_a, '0);
    // store of another core breaks the reservation
    add_entry(amo_lr,   1'b0, 6'd21, '0, core_a, '0);
    add_entry(amo_none, 1'b1, 6'd21, 32'h0000_beef, core_b, '0);
    add_entry(amo_sc,   1'b0, 6'd21, 32'h5c5c_0002, core_a, 32'd1);
    add_entry(amo_none, 1'b0, 6'd21, '0, core_a, '0);
    // no reservation at all
    add_entry(amo_sc,   1'b0, 6'd22, 32'h5c5c_0003, core_b, 32'd1);
    add_entry(amo_none, 1'b0, 6'd22, '0, core_b, '0);
    // SC of a foreign core fails and leaves the owner's reservation
    add_entry(amo_lr,   1'b0, 6'd23, '0, core_a, '0);
    add_entry(amo_sc,   1'b0, 6'd23, 32'h5c5c_0004, core_b, 32'd1);
    add_entry(amo_sc,   1'b0, 6'd23, 32'h5c5c_0005, core_a, 32'd0);
    add_entry(amo_none, 1'b0, 6'd23, '0, core_a, '0);
  endtask

  task automatic check_idle();
    checks++;
    if (in_valid_o || out_req_o || out_write_o) begin
      errors++;
      $display("FAIL %0t: idle outputs valid %b req %b write %b", $time,
               in_valid_o, out_req_o, out_write_o);
    end
  endtask

  // ------------------------------
  // drive one table row until accepted, update the reference
  // ------------------------------
  task automatic issue(input int k);
    logic       accepted;
    logic       is_store;
    logic       is_rmw_op;
    logic       exp_we;
    logic [5:0] idx;
    idx          = tab_idx[k];
    is_store     = tab_we[k] && (tab_op[k] == amo_none);
    is_rmw_op    = (tab_op[k] >= amo_swap) && (tab_op[k] <= amo_minu);
    exp_we       = is_store || ((tab_op[k] == amo_sc) && (tab_exp[k] == '0));
    in_valid_i   = 1'b1;
    in_address_i = {24'd0, idx, 2'b00};
    in_amo_i     = tab_op[k];
    in_write_i   = tab_we[k];
    in_wdata_i   = tab_data[k];
    in_meta_i    = meta_t'({tab_core[k], k[5:0]});
    in_be_i      = '1;
    accepted     = 1'b0;
    while (!accepted) begin
      // ready is settled by the negative edge
      @(negedge clk_i);
      if (in_ready_o) begin
        accepted = 1'b1;
        checks++;
        if (!out_req_o || (out_write_o !== exp_we)) begin
          errors++;
          $display("FAIL %0t: row %0d bank req %b write %b, expected write %b", $time, k,
                   out_req_o, out_write_o, exp_we);
        end
        if (is_store) begin
          shadow[idx] = tab_data[k];
        end else begin
          exp_meta_q.push_back(meta_t'({tab_core[k], k[5:0]}));
          if (tab_op[k] == amo_sc) begin
            exp_data_q.push_back(tab_exp[k]);
            if (tab_exp[k] == '0) begin
              shadow[idx] = tab_data[k];
            end
          end else begin
            // load, LR and AMO all return the old word
            exp_data_q.push_back(shadow[idx]);
            if (is_rmw_op) begin
              shadow[idx] = amo_ref(tab_op[k], shadow[idx], tab_data[k]);
            end
          end
        end
      end
      @(posedge clk_i);
      #2;
    end
  endtask

  // ------------------------------
  // SRAM model and core back-pressure
  // ------------------------------
  initial begin
    data_t mask;
    int    w;
    int    b;
    out_rdata_i = '0;
    for (w = 0; w < 64; w++) begin
      sram[w] = fill_word(w);
    end
    forever begin
      @(posedge clk_i);
      if (out_req_o && out_write_o) begin
        for (b = 0; b < be_width; b++) begin
          mask[8*b +: 8] = {8{out_be_o[b]}};
        end
        sram[out_add_o[7:2]] <= (sram[out_add_o[7:2]] & ~mask) | (out_wdata_o & mask);
      end else if (out_req_o) begin
        out_rdata_i <= sram[out_add_o[7:2]];
      end
    end
  end

  initial begin
    in_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      // low about three cycles in eight
      in_ready_i = (($random(seed) & 7) > 2);
    end
  end

  // ------------------------------
  // response checker
  // ------------------------------
  initial begin
    logic  held;
    data_t held_data;
    meta_t held_meta;
    data_t e_data;
    meta_t e_meta;
    held = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        if (held) begin
          checks++;
          if (!in_valid_o || in_rdata_o !== held_data || in_meta_o !== held_meta) begin
            errors++;
            $display("FAIL %0t: stalled response changed to valid %b data %h meta %h",
                     $time, in_valid_o, in_rdata_o, in_meta_o);
          end
        end
        held = in_valid_o && !in_ready_i;
        held_data = in_rdata_o;
        held_meta = in_meta_o;
        if (held && in_ready_o) begin
          errors++;
          $display("FAIL %0t: in_ready_o high while a response is stalled", $time);
        end
        if (in_valid_o && in_ready_i) begin
          if (exp_data_q.size() == 0) begin
            errors++;
            $display("response taken at %0t with no request outstanding", $time);
          end else begin
            e_data = exp_data_q.pop_front();
            e_meta = exp_meta_q.pop_front();
            checks++;
            if (in_rdata_o !== e_data || in_meta_o !== e_meta) begin
              errors++;
              $display("FAIL %0t: response data %h meta %h, expected data %h meta %h",
                       $time, in_rdata_o, in_meta_o, e_data, e_meta);
            end
          end
        end
      end
    end
  end

  // run limit grows with the table
  initial begin
    wait (tab_len != 0);
    repeat (tab_len * 50 + 20) @(posedge clk_i);
    $display("watchdog expired, responses still missing: %0d", exp_data_q.size());
    $display("tests failed");
    $finish;
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    errors       = 0;
    checks       = 0;
    rst_ni       = 1'b0;
    in_valid_i   = 1'b0;
    in_address_i = '0;
    in_amo_i     = '0;
    in_write_i   = 1'b0;
    in_wdata_i   = '0;
    in_meta_i    = '0;
    in_be_i      = '0;
    build_table();
    for (i = 0; i < 64; i++) begin
      shadow[i] = fill_word(i);
    end
    repeat (9) @(posedge clk_i);
    @(negedge clk_i);
    check_idle();
    @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    #2;
    for (i = 0; i < tab_len; i++) begin
      issue(i);
    end
    in_valid_i = 1'b0;
    while (exp_data_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
    // whole array against the reference, catches stray writes
    for (i = 0; i < 64; i++) begin
      checks++;
      if (sram[i] !== shadow[i]) begin
        errors++;
        $display("FAIL %0t: sram word %0d holds %h, expected %h", $time, i, sram[i], shadow[i]);
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
